// File: rtl/load_pkg.sv
// load-side definitions shared by the load unit blocks
// 64-bit data path only, integer loads only
// addresses reaching the unit are already physical

package load_pkg;

  // ------------------------------
  // data path
  // ------------------------------

  // width of a register and of a cache data word
  localparam int unsigned XLEN = 64;

  // bytes per data word
  localparam int unsigned BYTES = XLEN / 8;

  // low address bits that pick a byte inside a word
  localparam int unsigned ALIGN_BITS = $clog2(BYTES);

  // scoreboard id carried with each load
  localparam int unsigned TRANS_ID_BITS = 4;

  // ------------------------------
  // load kinds
  // ------------------------------

  // u suffix means zero extension, the others sign extend
  typedef enum logic [2:0] {
    LD  = 3'd0,
    LW  = 3'd1,
    LWU = 3'd2,
    LH  = 3'd3,
    LHU = 3'd4,
    LB  = 3'd5,
    LBU = 3'd6
  } ld_op_e;

endpackage

// File: rtl/dcache_pkg.sv
// field widths of the data cache load port
// index equals the 4 KiB page offset, tag holds the rest of the address

package dcache_pkg;

  localparam int unsigned INDEX_WIDTH = 12;
  localparam int unsigned TAG_WIDTH   = 44;
  localparam int unsigned ADDR_WIDTH  = INDEX_WIDTH + TAG_WIDTH;

  // request id on the port, wide enough for every load buffer slot
  localparam int unsigned ID_WIDTH = 4;

  // transfer size codes, log2 of the byte count
  localparam logic [1:0] SIZE_BYTE  = 2'd0;
  localparam logic [1:0] SIZE_HALF  = 2'd1;
  localparam logic [1:0] SIZE_WORD  = 2'd2;
  localparam logic [1:0] SIZE_DWORD = 2'd3;

  // transfer size of a load kind
  function automatic logic [1:0] size_for(load_pkg::ld_op_e op);
    case (op)
      load_pkg::LW, load_pkg::LWU: return SIZE_WORD;
      load_pkg::LH, load_pkg::LHU: return SIZE_HALF;
      load_pkg::LB, load_pkg::LBU: return SIZE_BYTE;
      default:                     return SIZE_DWORD;
    endcase
  endfunction

endpackage

// File: rtl/load_buffer.sv
// table of loads outstanding at the data cache, one slot per cache request id
// a slot is taken at grant and freed by its response, whatever the order
// flushed slots still wait for their response but never report it as live
`timescale 1ns/10ps

module load_buffer #(
  parameter int unsigned NrLoadBufEntries = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  ldbuf_w_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0]    trans_id_i,
  input  logic [load_pkg::ALIGN_BITS-1:0]       offset_i,
  input  load_pkg::ld_op_e                      op_i,
  input  logic                                  kill_req_i,
  input  logic                                  data_rvalid_i,
  input  logic [dcache_pkg::ID_WIDTH-1:0]       data_rid_i,
  output logic                                  ldbuf_full_o,
  output logic [dcache_pkg::ID_WIDTH-1:0]       data_id_o,
  output logic                                  rsp_live_o,
  output logic [load_pkg::TRANS_ID_BITS-1:0]    rsp_trans_id_o,
  output logic [load_pkg::ALIGN_BITS-1:0]       rsp_offset_o,
  output load_pkg::ld_op_e                      rsp_op_o
);
  localparam int unsigned IdxW = $clog2(NrLoadBufEntries);
  localparam int unsigned IdW  = dcache_pkg::ID_WIDTH;

  // slot number has to fit in the cache request id
  if (IdxW > IdW) begin : gen_id_too_narrow
    $error("load buffer slot index does not fit the cache request id");
  end

  logic [NrLoadBufEntries-1:0]        valid_q, valid_d;
  logic [NrLoadBufEntries-1:0]        flushed_q, flushed_d;
  logic [load_pkg::TRANS_ID_BITS-1:0] trans_id_q [NrLoadBufEntries];
  logic [load_pkg::ALIGN_BITS-1:0]    offset_q [NrLoadBufEntries];
  load_pkg::ld_op_e                   op_q [NrLoadBufEntries];
  logic [IdxW-1:0]                    free_idx;
  logic [IdxW-1:0]                    rd_idx;
  logic [IdxW-1:0]                    last_id_q;

  // lowest free slot wins, scanned from the top so low slots overwrite
  always_comb begin : free_search
    free_idx = '0;
    for (int i = NrLoadBufEntries - 1; i >= 0; i--) begin
      if (!valid_q[i]) free_idx = IdxW'(i);
    end
  end

  assign ldbuf_full_o = &valid_q;
  assign data_id_o    = IdW'(free_idx);
  assign rd_idx       = data_rid_i[IdxW-1:0];

  always_comb begin : slot_next
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight at a flush is dropped on return
    if (flush_i) flushed_d = '1;
    // a response always frees its slot, live or not
    if (data_rvalid_i) valid_d[rd_idx] = 1'b0;
    if (ldbuf_w_i) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : slot_ctrl
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      // remembered for the kill in the tag phase
      if (ldbuf_w_i) last_id_q <= free_idx;
    end
  end

  always_ff @(posedge clk_i) begin : slot_data
    if (ldbuf_w_i) begin
      trans_id_q[free_idx] <= trans_id_i;
      offset_q[free_idx]   <= offset_i;
      op_q[free_idx]       <= op_i;
    end
  end

  // stored entry picked by the response id
  assign rsp_trans_id_o = trans_id_q[rd_idx];
  assign rsp_offset_o   = offset_q[rd_idx];
  assign rsp_op_o       = op_q[rd_idx];

  // a response racing its own kill is not reported
  assign rsp_live_o = data_rvalid_i && !flushed_q[rd_idx] &&
                      !(kill_req_i && (last_id_q == rd_idx));

  // ------------------------------
  // checks
  // ------------------------------

  // the state machine only writes when not full
  a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldbuf_w_i |-> !valid_q[free_idx])
    else $error("load buffer write to an occupied slot");

  // the cache answers only ids it was granted
  a_rsp_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> (data_rid_i < IdW'(NrLoadBufEntries)) && valid_q[rd_idx])
    else $error("response for a slot with no outstanding load");

  // misaligned loads must not have reached the cache
  a_offset_ok : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |->
      ((rsp_op_o inside {load_pkg::LW, load_pkg::LWU}) -> (rsp_offset_o < 3'd5)) &&
      ((rsp_op_o inside {load_pkg::LH, load_pkg::LHU}) -> (rsp_offset_o < 3'd7)))
    else $error("stored load offset crosses the data word");

endmodule

// File: rtl/load_req_fsm.sv
// request side of the load unit toward the data cache
// index phase is held until grant, tag phase follows exactly one cycle later
// a flush drops any request not yet granted and kills the last one
// no fall-through path, so at least two buffer slots are needed
`timescale 1ns/10ps

module load_req_fsm #(
  parameter int unsigned NrLoadBufEntries = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  valid_i,
  input  load_pkg::ld_op_e                      op_i,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]     vaddr_i,
  input  logic                                  page_offset_matches_i,
  input  logic                                  data_gnt_i,
  input  logic                                  ldbuf_full_i,
  output logic                                  pop_ld_o,
  output logic                                  data_req_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]    address_index_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]      address_tag_o,
  output logic [load_pkg::BYTES-1:0]            data_be_o,
  output logic [1:0]                            data_size_o,
  output logic                                  tag_valid_o,
  output logic                                  kill_req_o,
  output logic                                  ldbuf_w_o
);
  if (NrLoadBufEntries < 2) begin : gen_too_few_slots
    $error("load buffer needs at least two slots");
  end

  enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } state_d, state_q;

  logic                             accept_req;
  logic [load_pkg::BYTES-1:0]       be_base;
  logic [dcache_pkg::TAG_WIDTH-1:0] tag_q;

  // a new load may start only with a free slot for it
  assign accept_req = valid_i && !ldbuf_full_i;

  // ------------------------------
  // state machine
  // ------------------------------
  always_comb begin : req_ctrl
    state_d     = state_q;
    data_req_o  = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;
    unique case (state_q)
      // send tag overlaps with the next index phase
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // pending store to the same offset, hold back
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            state_d    = data_gnt_i ? SEND_TAG : WAIT_GNT;
          end
        end
      end
      // index phase starts in the cycle the match clears
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          data_req_o = 1'b1;
          state_d    = data_gnt_i ? SEND_TAG : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) state_d = SEND_TAG;
      end
      // kill whatever the cache still holds from us
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase
    // nothing new is granted in the flush cycle
    if (flush_i) begin
      data_req_o = 1'b0;
      state_d    = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // grant consumes the request and claims a slot
  assign ldbuf_w_o = data_req_o & data_gnt_i;
  assign pop_ld_o  = ldbuf_w_o;

  // ------------------------------
  // address and byte lanes
  // ------------------------------
  assign address_index_o = vaddr_i[dcache_pkg::INDEX_WIDTH-1:0];
  assign data_size_o     = dcache_pkg::size_for(op_i);

  always_comb begin : be_sel
    case (op_i)
      load_pkg::LW, load_pkg::LWU: be_base = 8'h0f;
      load_pkg::LH, load_pkg::LHU: be_base = 8'h03;
      load_pkg::LB, load_pkg::LBU: be_base = 8'h01;
      default:                     be_base = 8'hff;
    endcase
  end

  assign data_be_o = be_base << vaddr_i[load_pkg::ALIGN_BITS-1:0];

  // tag for the cycle after grant
  always_ff @(posedge clk_i) begin : tag_reg
    if (ldbuf_w_o) tag_q <= vaddr_i[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::INDEX_WIDTH];
  end

  assign address_tag_o = tag_q;

  // index phase is never withdrawn except by a flush
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o || flush_i)
    else $error("data request dropped before grant");

endmodule

// File: rtl/load_align.sv
// aligns a returned cache word to the loaded field and extends it
// offset and kind come from the load buffer entry of the response
// sign bit is picked from the raw word in parallel with the shifter
`timescale 1ns/10ps

module load_align (
  input  logic [load_pkg::XLEN-1:0]       rdata_i,
  input  logic [load_pkg::ALIGN_BITS-1:0] offset_i,
  input  load_pkg::ld_op_e                op_i,
  output logic [load_pkg::XLEN-1:0]       result_o
);
  localparam int unsigned XLEN = load_pkg::XLEN;

  logic [XLEN-1:0]                 shifted;
  logic [load_pkg::BYTES-1:0]      sign_bits;
  logic [load_pkg::ALIGN_BITS-1:0] sign_idx;
  logic                            is_signed;
  logic                            sign_bit;

  // byte offset to bit shift
  assign shifted = rdata_i >> {offset_i, 3'b000};

  // top bit of every byte lane
  for (genvar i = 0; i < load_pkg::BYTES; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[8*i+7];
  end

  assign is_signed = op_i inside {load_pkg::LW, load_pkg::LH, load_pkg::LB};

  // lane holding the top byte of the accessed field
  assign sign_idx = (op_i inside {load_pkg::LW, load_pkg::LWU}) ?
                      offset_i + load_pkg::ALIGN_BITS'(3) :
                    (op_i inside {load_pkg::LH, load_pkg::LHU}) ?
                      offset_i + load_pkg::ALIGN_BITS'(1) :
                      offset_i;

  // unsigned kinds fill with zero
  assign sign_bit = is_signed & sign_bits[sign_idx];

  // ------------------------------
  // result mux
  // ------------------------------
  always_comb begin : result_mux
    case (op_i)
      load_pkg::LW, load_pkg::LWU: result_o = {{XLEN - 32{sign_bit}}, shifted[31:0]};
      load_pkg::LH, load_pkg::LHU: result_o = {{XLEN - 16{sign_bit}}, shifted[15:0]};
      load_pkg::LB, load_pkg::LBU: result_o = {{XLEN - 8{sign_bit}}, shifted[7:0]};
      // doubleword is always aligned, passes through
      default:                     result_o = shifted;
    endcase
  end

endmodule

// File: rtl/load_unit.sv
// load unit for the data cache port of a 64-bit in-order core
// up to NrLoadBufEntries loads in flight, responses may return in any order
// vaddr_i is taken as physical, there is no translation here
// valid_o is a one-cycle strobe with no back-pressure
`timescale 1ns/10ps

module load_unit #(
  parameter int unsigned NrLoadBufEntries = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  // request from the bypass queue
  input  logic                                  valid_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0]    trans_id_i,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]     vaddr_i,
  input  load_pkg::ld_op_e                      op_i,
  output logic                                  pop_ld_o,
  // store unit address check
  output logic [dcache_pkg::INDEX_WIDTH-1:0]    page_offset_o,
  input  logic                                  page_offset_matches_i,
  // cache index phase
  output logic                                  data_req_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]    address_index_o,
  output logic [load_pkg::BYTES-1:0]            data_be_o,
  output logic [1:0]                            data_size_o,
  output logic [dcache_pkg::ID_WIDTH-1:0]       data_id_o,
  input  logic                                  data_gnt_i,
  // cache tag phase
  output logic [dcache_pkg::TAG_WIDTH-1:0]      address_tag_o,
  output logic                                  tag_valid_o,
  output logic                                  kill_req_o,
  // cache response
  input  logic                                  data_rvalid_i,
  input  logic [dcache_pkg::ID_WIDTH-1:0]       data_rid_i,
  input  logic [load_pkg::XLEN-1:0]             data_rdata_i,
  // result to the issue stage
  output logic                                  valid_o,
  output logic [load_pkg::TRANS_ID_BITS-1:0]    trans_id_o,
  output logic [load_pkg::XLEN-1:0]             result_o
);
  logic                            ldbuf_w;
  logic                            ldbuf_full;
  logic [load_pkg::ALIGN_BITS-1:0] rsp_offset;
  load_pkg::ld_op_e                rsp_op;

  // store check compares the page offset only
  assign page_offset_o = vaddr_i[dcache_pkg::INDEX_WIDTH-1:0];

  load_req_fsm #(
    .NrLoadBufEntries (NrLoadBufEntries)
  ) u_req_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .op_i                  (op_i),
    .vaddr_i               (vaddr_i),
    .page_offset_matches_i (page_offset_matches_i),
    .data_gnt_i            (data_gnt_i),
    .ldbuf_full_i          (ldbuf_full),
    .pop_ld_o              (pop_ld_o),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .data_be_o             (data_be_o),
    .data_size_o           (data_size_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .ldbuf_w_o             (ldbuf_w)
  );

  // free slot index doubles as the cache request id
  load_buffer #(
    .NrLoadBufEntries (NrLoadBufEntries)
  ) u_load_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .ldbuf_w_i      (ldbuf_w),
    .trans_id_i     (trans_id_i),
    .offset_i       (vaddr_i[load_pkg::ALIGN_BITS-1:0]),
    .op_i           (op_i),
    .kill_req_i     (kill_req_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rid_i     (data_rid_i),
    .ldbuf_full_o   (ldbuf_full),
    .data_id_o      (data_id_o),
    .rsp_live_o     (valid_o),
    .rsp_trans_id_o (trans_id_o),
    .rsp_offset_o   (rsp_offset),
    .rsp_op_o       (rsp_op)
  );

  load_align u_load_align (
    .rdata_i  (data_rdata_i),
    .offset_i (rsp_offset),
    .op_i     (rsp_op),
    .result_o (result_o)
  );

endmodule

// File: dv/load_checker.sv
// watches the load unit ports and compares every result with a model
// slot table is keyed by the cache request id seen at grant
// ports are sampled at the falling edge, where all of them are settled
`timescale 1ns/10ps

module load_checker #(
  parameter int unsigned NrLoadBufEntries = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [dcache_pkg::ADDR_WIDTH-1:0]  vaddr_i,
  input  load_pkg::ld_op_e                   op_i,
  input  logic                               pop_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0] page_off_i,
  input  logic                               match_i,
  input  logic                               req_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0] index_i,
  input  logic [load_pkg::BYTES-1:0]         be_i,
  input  logic [1:0]                         size_i,
  input  logic                               gnt_i,
  input  logic [dcache_pkg::ID_WIDTH-1:0]    id_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]   tag_i,
  input  logic                               tag_valid_i,
  input  logic                               kill_i,
  input  logic                               rvalid_i,
  input  logic [dcache_pkg::ID_WIDTH-1:0]    rid_i,
  input  logic [load_pkg::XLEN-1:0]          rdata_i,
  input  logic                               res_valid_i,
  input  logic [load_pkg::TRANS_ID_BITS-1:0] res_id_i,
  input  logic [load_pkg::XLEN-1:0]          result_i,
  output int                                 err_cnt_o,
  output int                                 busy_cnt_o
);
  localparam int unsigned Slots = 1 << dcache_pkg::ID_WIDTH;

  logic                               busy [Slots];
  logic                               dropped [Slots];
  logic [load_pkg::TRANS_ID_BITS-1:0] slot_tid [Slots];
  logic [load_pkg::ALIGN_BITS-1:0]    slot_off [Slots];
  load_pkg::ld_op_e                   slot_op [Slots];
  logic [dcache_pkg::TAG_WIDTH-1:0]   tag_q;
  logic                               req_q;
  logic                               gnt_q;
  logic                               flush_q;
  logic                               after_rst;
  int                                 errors = 0;
  int                                 busy_cnt = 0;

  assign err_cnt_o  = errors;
  assign busy_cnt_o = busy_cnt;

  // reference result, field moved down and its top bit copied up for signed kinds
  function automatic logic [load_pkg::XLEN-1:0] expected(
    logic [load_pkg::XLEN-1:0]       data,
    logic [load_pkg::ALIGN_BITS-1:0] off,
    load_pkg::ld_op_e                op
  );
    logic [load_pkg::XLEN-1:0] f;
    f = data >> (8 * int'(off));
    case (op)
      load_pkg::LW:  return {{32{f[31]}}, f[31:0]};
      load_pkg::LWU: return {32'h0, f[31:0]};
      load_pkg::LH:  return {{48{f[15]}}, f[15:0]};
      load_pkg::LHU: return {48'h0, f[15:0]};
      load_pkg::LB:  return {{56{f[7]}}, f[7:0]};
      load_pkg::LBU: return {56'h0, f[7:0]};
      default:       return f;
    endcase
  endfunction

  // bytes touched by a load kind
  function automatic int access_bytes(load_pkg::ld_op_e op);
    case (op)
      load_pkg::LW, load_pkg::LWU: return 4;
      load_pkg::LH, load_pkg::LHU: return 2;
      load_pkg::LB, load_pkg::LBU: return 1;
      default:                     return 8;
    endcase
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  always @(negedge clk_i) begin : monitor
    logic                               new_phase;
    int                                 nbytes;
    logic [dcache_pkg::INDEX_WIDTH-1:0] exp_idx;
    logic [load_pkg::BYTES-1:0]         exp_be;
    logic [1:0]                         exp_size;
    if (!rst_ni) begin
      if (pop_i || req_i || tag_valid_i || kill_i || res_valid_i)
        flag_error("output active during reset");
      for (int i = 0; i < Slots; i++) begin
        busy[i]    = 1'b0;
        dropped[i] = 1'b0;
      end
      req_q     = 1'b0;
      gnt_q     = 1'b0;
      flush_q   = 1'b0;
      after_rst = 1'b1;
    end else begin
      if (after_rst && (pop_i || req_i || tag_valid_i || kill_i || res_valid_i))
        flag_error("output active in the first cycle after reset");
      after_rst = 1'b0;

      // ------------------------------
      // request side
      // ------------------------------
      // a phase starts from no request or right after a grant
      new_phase = req_i && (!req_q || gnt_q);
      if (new_phase && match_i)
        flag_error("index phase started during a page offset match");
      if ((new_phase || pop_i) && busy_cnt == int'(NrLoadBufEntries))
        flag_error("request issued with all buffer slots in use");
      if (pop_i !== (req_i && gnt_i))
        flag_error("pop_ld_o does not follow the grant");
      if (req_i && gnt_i && (busy[id_i] || int'(id_i) >= int'(NrLoadBufEntries)))
        flag_error($sformatf("grant on busy or unknown id %0d", id_i));

      // index and store check both carry the page offset
      exp_idx = vaddr_i[dcache_pkg::INDEX_WIDTH-1:0];
      if (page_off_i !== exp_idx)
        flag_error($sformatf("page offset %h, expected %h", page_off_i, exp_idx));
      if (req_i) begin
        // one enable per accessed byte, size is log2 of the byte count
        nbytes   = access_bytes(op_i);
        exp_be   = load_pkg::BYTES'((1 << nbytes) - 1);
        exp_be   = exp_be << vaddr_i[load_pkg::ALIGN_BITS-1:0];
        exp_size = 2'($clog2(nbytes));
        if (index_i !== exp_idx)
          flag_error($sformatf("index %h, expected %h", index_i, exp_idx));
        if (be_i !== exp_be)
          flag_error($sformatf("byte enables %h, expected %h", be_i, exp_be));
        if (size_i !== exp_size)
          flag_error($sformatf("size %0d, expected %0d", size_i, exp_size));
      end

      // tag phase one cycle after grant, kill one cycle after flush
      if (tag_valid_i !== (gnt_q || flush_q))
        flag_error("tag_valid_o not one cycle after grant or flush");
      if (kill_i !== flush_q)
        flag_error("kill_req_o not one cycle after flush");
      if (gnt_q && tag_i !== tag_q)
        flag_error($sformatf("tag %h, expected %h", tag_i, tag_q));

      // ------------------------------
      // response side
      // ------------------------------
      if (rvalid_i) begin
        if (!busy[rid_i]) begin
          flag_error($sformatf("response for id %0d with no load", rid_i));
        end else if (dropped[rid_i]) begin
          if (res_valid_i) flag_error("result for a flushed load");
        end else if (!res_valid_i) begin
          flag_error($sformatf("no result for id %0d", rid_i));
        end else begin
          if (res_id_i !== slot_tid[rid_i])
            flag_error($sformatf("trans id %0h, expected %0h", res_id_i, slot_tid[rid_i]));
          if (result_i !== expected(rdata_i, slot_off[rid_i], slot_op[rid_i]))
            flag_error($sformatf("result %h, expected %h", result_i,
                                 expected(rdata_i, slot_off[rid_i], slot_op[rid_i])));
        end
        busy[rid_i] = 1'b0;
      end else if (res_valid_i) begin
        flag_error("valid_o without a cache response");
      end

      // everything in flight now is dropped
      if (flush_i) begin
        for (int i = 0; i < Slots; i++) dropped[i] = 1'b1;
      end
      if (req_i && gnt_i) begin
        busy[id_i]     = 1'b1;
        dropped[id_i]  = 1'b0;
        slot_tid[id_i] = trans_id_i;
        slot_off[id_i] = vaddr_i[load_pkg::ALIGN_BITS-1:0];
        slot_op[id_i]  = op_i;
        tag_q          = vaddr_i[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::INDEX_WIDTH];
      end
      req_q   = req_i;
      gnt_q   = req_i && gnt_i;
      flush_q = flush_i;
    end
    busy_cnt = 0;
    for (int i = 0; i < Slots; i++) begin
      if (busy[i]) busy_cnt++;
    end
  end

endmodule

// File: dv/tb_load_unit.sv
// testbench for the load unit with a random out of order cache model
// requests use naturally aligned offsets only, so no load crosses a word
// the cache answers every grant exactly once, killed ones included
`timescale 1ns/10ps

module tb_load_unit;
  localparam int unsigned NrLoadBufEntries = 4;
  localparam int          NumCycles        = 3000;
  localparam int          WaitLimit        = 200;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               valid_i;
  logic [load_pkg::TRANS_ID_BITS-1:0] trans_id_i;
  logic [dcache_pkg::ADDR_WIDTH-1:0]  vaddr_i;
  load_pkg::ld_op_e                   op_i;
  logic                               pop_ld_o;
  logic [dcache_pkg::INDEX_WIDTH-1:0] page_offset_o;
  logic                               page_offset_matches_i;
  logic                               data_req_o;
  logic [dcache_pkg::INDEX_WIDTH-1:0] address_index_o;
  logic [load_pkg::BYTES-1:0]         data_be_o;
  logic [1:0]                         data_size_o;
  logic [dcache_pkg::ID_WIDTH-1:0]    data_id_o;
  logic                               data_gnt_i;
  logic [dcache_pkg::TAG_WIDTH-1:0]   address_tag_o;
  logic                               tag_valid_o;
  logic                               kill_req_o;
  logic                               data_rvalid_i;
  logic [dcache_pkg::ID_WIDTH-1:0]    data_rid_i;
  logic [load_pkg::XLEN-1:0]          data_rdata_i;
  logic                               valid_o;
  logic [load_pkg::TRANS_ID_BITS-1:0] trans_id_o;
  logic [load_pkg::XLEN-1:0]          result_o;

  int                                 seed;
  int                                 cycle;
  int                                 req_wait;
  int                                 drain;
  int                                 err_cnt;
  int                                 busy_cnt;
  logic                               stim_on;
  logic                               timed_out;
  // cache model, granted ids and the cycle each may be answered
  logic [dcache_pkg::ID_WIDTH-1:0]    pend_id [$];
  int                                 pend_due [$];

  load_unit #(
    .NrLoadBufEntries (NrLoadBufEntries)
  ) u_dut (.*);

  load_checker #(
    .NrLoadBufEntries (NrLoadBufEntries)
  ) u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .trans_id_i  (trans_id_i),
    .vaddr_i     (vaddr_i),
    .op_i        (op_i),
    .pop_i       (pop_ld_o),
    .page_off_i  (page_offset_o),
    .match_i     (page_offset_matches_i),
    .req_i       (data_req_o),
    .index_i     (address_index_o),
    .be_i        (data_be_o),
    .size_i      (data_size_o),
    .gnt_i       (data_gnt_i),
    .id_i        (data_id_o),
    .tag_i       (address_tag_o),
    .tag_valid_i (tag_valid_o),
    .kill_i      (kill_req_o),
    .rvalid_i    (data_rvalid_i),
    .rid_i       (data_rid_i),
    .rdata_i     (data_rdata_i),
    .res_valid_i (valid_o),
    .res_id_i    (trans_id_o),
    .result_i    (result_o),
    .err_cnt_o   (err_cnt),
    .busy_cnt_o  (busy_cnt)
  );

  // 100 ns clock
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic chance(int pct);
    return (next_rand() % 100) < pct;
  endfunction

  // ------------------------------
  // stimulus
  // ------------------------------
  // offset is a multiple of the access size
  task automatic new_request();
    logic [31:0]                     r0;
    logic [31:0]                     r1;
    logic [load_pkg::ALIGN_BITS-1:0] off;
    load_pkg::ld_op_e                op;
    r0 = next_rand();
    r1 = next_rand();
    op = load_pkg::ld_op_e'(3'(r0 % 7));
    case (op)
      load_pkg::LW, load_pkg::LWU: off = {r0[8], 2'b00};
      load_pkg::LH, load_pkg::LHU: off = {r0[9:8], 1'b0};
      load_pkg::LB, load_pkg::LBU: off = r0[10:8];
      default:                     off = 3'd0;
    endcase
    valid_i    = 1'b1;
    trans_id_i = r0[15:12];
    op_i       = op;
    vaddr_i    = {r0[31:16], r1, r0[4:0], off};
  endtask

  // observe one cycle at the falling edge, then drive the next one
  task automatic step();
    logic                            popped;
    logic                            granted;
    logic [dcache_pkg::ID_WIDTH-1:0] gnt_id;
    logic [31:0]                     r;
    int                              pick;
    @(negedge clk_i);
    popped  = pop_ld_o;
    granted = data_req_o && data_gnt_i;
    gnt_id  = data_id_o;
    @(posedge clk_i);
    #1;
    cycle++;
    if (granted) begin
      r = next_rand();
      pend_id.push_back(gnt_id);
      pend_due.push_back(cycle + int'(r[3:0]));
    end
    // answer one random pending request once its delay is over
    data_rvalid_i = 1'b0;
    if (pend_id.size() != 0) begin
      r    = next_rand();
      pick = int'(r[7:0]) % pend_id.size();
      if (pend_due[pick] <= cycle) begin
        data_rvalid_i = 1'b1;
        data_rid_i    = pend_id[pick];
        data_rdata_i  = {next_rand(), next_rand()};
        pend_id.delete(pick);
        pend_due.delete(pick);
      end
    end
    data_gnt_i            = chance(60);
    page_offset_matches_i = chance(20);
    if (popped) valid_i = 1'b0;
    // the bypass queue is emptied by a flush too
    flush_i = stim_on && chance(2);
    if (flush_i) valid_i = 1'b0;
    if (!valid_i) req_wait = 0;
    if (!valid_i && !flush_i && stim_on && chance(60)) new_request();
    if (valid_i) req_wait++;
    if (req_wait > WaitLimit && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: request not popped after %0d cycles", WaitLimit);
    end
  endtask

  initial begin
    seed                  = 22011;
    cycle                 = 0;
    req_wait              = 0;
    drain                 = 0;
    stim_on               = 1'b1;
    timed_out             = 1'b0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    trans_id_i            = '0;
    vaddr_i               = '0;
    op_i                  = load_pkg::LD;
    page_offset_matches_i = 1'b0;
    data_gnt_i            = 1'b0;
    data_rvalid_i         = 1'b0;
    data_rid_i            = '0;
    data_rdata_i          = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int n = 0; n < NumCycles && !timed_out; n++) step();

    // let every outstanding load come back
    stim_on = 1'b0;
    while (!timed_out && (valid_i || pend_id.size() != 0)) begin
      step();
      drain++;
      if (drain > WaitLimit) begin
        timed_out = 1'b1;
        $display("timeout: outstanding loads not drained after %0d cycles", WaitLimit);
      end
    end
    repeat (2) step();

    $display("load unit test done after %0d cycles: %0d errors, %0d loads left outstanding",
             cycle, err_cnt, busy_cnt);
    if (timed_out || err_cnt != 0 || busy_cnt != 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/load_pkg.sv
rtl/dcache_pkg.sv
rtl/load_buffer.sv
rtl/load_req_fsm.sv
rtl/load_align.sv
rtl/load_unit.sv
dv/load_checker.sv
dv/tb_load_unit.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the load unit testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_load_unit \
  -Mdir "$BUILD_DIR" -o sim_tb -f filelist.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  echo "test failed, see $LOG"
  exit 1
fi
echo "test passed"
exit 0
